// File: rtl/scheduler_pkg.sv
package scheduler_pkg;

    localparam int NUM_QUEUES = 5;
    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = DATA_WIDTH / 8;
    localparam int META_WIDTH = 32;
    localparam int PIFO_INFO_WIDTH = 32;
    localparam int RANK_WIDTH = 16;
    localparam int TUSER_WIDTH = META_WIDTH + PIFO_INFO_WIDTH;

    // Top bit of the scheduling word flags a valid rank
    localparam int PIFO_VALID_BIT = PIFO_INFO_WIDTH - 1;

    // Stored word holds data, keep, last and meta from bit 0 up
    localparam int KEEP_LSB = DATA_WIDTH;
    localparam int LAST_BIT = KEEP_LSB + KEEP_WIDTH;
    localparam int META_LSB = LAST_BIT + 1;
    localparam int WORD_WIDTH = META_LSB + META_WIDTH;

    localparam int DEFAULT_NUM_SLOTS = 8;
    localparam int DEFAULT_SLOT_WORDS = 8;
    localparam int DEFAULT_PIFO_DEPTH = 8;

endpackage

// File: rtl/ingress_if.sv
`timescale 1ns/10ps

interface ingress_if;
    import scheduler_pkg::*;

    logic                       valid;
    logic                       last;
    logic [DATA_WIDTH-1:0]      data;
    logic [KEEP_WIDTH-1:0]      keep;
    logic [META_WIDTH-1:0]      meta;
    logic [PIFO_INFO_WIDTH-1:0] pifo_info;

    modport source (output valid, last, data, keep, meta, pifo_info);
    modport sink (input valid, last, data, keep, meta, pifo_info);

endinterface

// File: rtl/queue_ctl_if.sv
`timescale 1ns/10ps

interface queue_ctl_if;
    import scheduler_pkg::*;

    logic [NUM_QUEUES-1:0] wr_en;
    logic [NUM_QUEUES-1:0] pifo_insert_en;
    // One bit per queue, each driven by its own queue
    logic [NUM_QUEUES-1:0] buffer_full;
    logic [NUM_QUEUES-1:0] pifo_full;

    modport agent (output wr_en, pifo_insert_en, input buffer_full, pifo_full);
    modport queue (input wr_en, pifo_insert_en, output buffer_full, pifo_full);

endinterface

// File: rtl/packet_buffer.sv
`timescale 1ns/10ps

module packet_buffer #(
    parameter int NUM_SLOTS = scheduler_pkg::DEFAULT_NUM_SLOTS,
    parameter int SLOT_WORDS = scheduler_pkg::DEFAULT_SLOT_WORDS,
    localparam int SLOT_WIDTH = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1,
    localparam int INDEX_WIDTH = (SLOT_WORDS > 1) ? $clog2(SLOT_WORDS) : 1
) (
    input  logic                                 axis_aclk,
    input  logic                                 reset,
    input  logic                                 wr_en,
    input  logic                                 wr_first,
    input  logic                                 wr_last,
    input  logic [scheduler_pkg::WORD_WIDTH-1:0] wr_word,
    output logic [SLOT_WIDTH-1:0]                wr_slot,
    input  logic [SLOT_WIDTH-1:0]                rd_slot,
    input  logic [INDEX_WIDTH-1:0]               rd_index,
    output logic [scheduler_pkg::WORD_WIDTH-1:0] rd_word,
    input  logic                                 free_en,
    input  logic [SLOT_WIDTH-1:0]                free_slot,
    output logic                                 full
);
    import scheduler_pkg::*;

    logic [META_LSB-1:0]    word_mem [NUM_SLOTS][SLOT_WORDS];
    logic [META_WIDTH-1:0]  meta_mem [NUM_SLOTS];
    logic [NUM_SLOTS-1:0]   free_map;
    logic [SLOT_WIDTH-1:0]  alloc_slot;
    logic [SLOT_WIDTH-1:0]  cur_slot;
    logic [INDEX_WIDTH-1:0] wr_ptr;
    logic [INDEX_WIDTH-1:0] wr_index;

    // Lowest free slot wins
    always_comb begin
        alloc_slot = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                alloc_slot = SLOT_WIDTH'(i);
            end
        end
    end

    assign full = ~|free_map;
    assign wr_slot = wr_first ? alloc_slot : cur_slot;
    assign wr_index = wr_first ? '0 : wr_ptr;

    always_ff @(posedge axis_aclk) begin
        if (reset) begin
            free_map <= '1;
            cur_slot <= '0;
            wr_ptr <= '0;
        end else begin
            if (free_en) begin
                free_map[free_slot] <= 1'b1;
            end
            if (wr_en) begin
                if (wr_first) begin
                    free_map[alloc_slot] <= 1'b0;
                    cur_slot <= alloc_slot;
                end
                wr_ptr <= wr_last ? '0 : wr_index + 1'b1;
            end
        end
    end

    always_ff @(posedge axis_aclk) begin
        if (wr_en) begin
            word_mem[wr_slot][wr_index] <= wr_word[META_LSB-1:0];
            if (wr_first) begin
                meta_mem[wr_slot] <= wr_word[WORD_WIDTH-1:META_LSB];
            end
        end
        rd_word <= {meta_mem[rd_slot], word_mem[rd_slot][rd_index]};
    end

    // Agent must not admit a packet with no slot left
    assert property (@(posedge axis_aclk) disable iff (reset)
        wr_en && wr_first |-> !full);

    assert property (@(posedge axis_aclk) disable iff (reset)
        wr_en && !wr_last |-> wr_index != INDEX_WIDTH'(SLOT_WORDS - 1));

endmodule

// File: rtl/pifo_calendar.sv
`timescale 1ns/10ps

module pifo_calendar #(
    parameter int PIFO_DEPTH = scheduler_pkg::DEFAULT_PIFO_DEPTH,
    parameter int SLOT_WIDTH = 3,
    localparam int COUNT_WIDTH = $clog2(PIFO_DEPTH + 1)
) (
    input  logic                                      axis_aclk,
    input  logic                                      reset,
    input  logic                                      insert_en,
    input  logic [scheduler_pkg::RANK_WIDTH-1:0]      insert_rank,
    input  logic [SLOT_WIDTH-1:0]                     insert_slot,
    input  logic [scheduler_pkg::PIFO_INFO_WIDTH-1:0] insert_info,
    input  logic                                      pop_en,
    output logic                                      head_valid,
    output logic [SLOT_WIDTH-1:0]                     head_slot,
    output logic [scheduler_pkg::PIFO_INFO_WIDTH-1:0] head_info,
    output logic [COUNT_WIDTH-1:0]                    count,
    output logic                                      full
);
    import scheduler_pkg::*;

    logic [RANK_WIDTH-1:0]      rank_q   [PIFO_DEPTH];
    logic [SLOT_WIDTH-1:0]      slot_q   [PIFO_DEPTH];
    logic [PIFO_INFO_WIDTH-1:0] info_q   [PIFO_DEPTH];
    logic [RANK_WIDTH-1:0]      nxt_rank [PIFO_DEPTH];
    logic [SLOT_WIDTH-1:0]      nxt_slot [PIFO_DEPTH];
    logic [PIFO_INFO_WIDTH-1:0] nxt_info [PIFO_DEPTH];
    int                         ins_pos;
    int                         tgt_pos;
    int                         src;

    // New entry goes ahead of the first strictly higher rank
    always_comb begin
        ins_pos = int'(count);
        for (int i = PIFO_DEPTH - 1; i >= 0; i--) begin
            if (i < int'(count) && rank_q[i] > insert_rank) begin
                ins_pos = i;
            end
        end
        tgt_pos = (pop_en && ins_pos > 0) ? ins_pos - 1 : ins_pos;
    end

    // Pop shifts toward the head, insert opens a gap at tgt_pos
    always_comb begin
        for (int i = 0; i < PIFO_DEPTH; i++) begin
            src = (pop_en ? i + 1 : i) - ((insert_en && i > tgt_pos) ? 1 : 0);
            nxt_rank[i] = rank_q[i];
            nxt_slot[i] = slot_q[i];
            nxt_info[i] = info_q[i];
            if (insert_en && i == tgt_pos) begin
                nxt_rank[i] = insert_rank;
                nxt_slot[i] = insert_slot;
                nxt_info[i] = insert_info;
            end else if (src < PIFO_DEPTH) begin
                nxt_rank[i] = rank_q[src];
                nxt_slot[i] = slot_q[src];
                nxt_info[i] = info_q[src];
            end
        end
    end

    always_ff @(posedge axis_aclk) begin
        rank_q <= nxt_rank;
        slot_q <= nxt_slot;
        info_q <= nxt_info;
    end

    always_ff @(posedge axis_aclk) begin
        if (reset) begin
            count <= '0;
        end else begin
            count <= count + COUNT_WIDTH'(insert_en) - COUNT_WIDTH'(pop_en);
        end
    end

    assign head_valid = (count != '0);
    assign head_slot = slot_q[0];
    assign head_info = info_q[0];
    assign full = (count == COUNT_WIDTH'(PIFO_DEPTH));

    // Full was checked by the agent at the first beat
    assert property (@(posedge axis_aclk) disable iff (reset)
        insert_en |-> !full);

    assert property (@(posedge axis_aclk) disable iff (reset)
        pop_en |-> head_valid);

endmodule

// File: rtl/output_queue.sv
`timescale 1ns/10ps

module output_queue #(
    parameter int QUEUE_INDEX = 0,
    parameter int NUM_SLOTS   = scheduler_pkg::DEFAULT_NUM_SLOTS,
    parameter int SLOT_WORDS  = scheduler_pkg::DEFAULT_SLOT_WORDS,
    parameter int PIFO_DEPTH  = scheduler_pkg::DEFAULT_PIFO_DEPTH
) (
    input  logic                                      axis_aclk,
    input  logic                                      reset,
    ingress_if.sink                                   in_bus,
    queue_ctl_if.queue                                ctl,
    input  logic                                      m_axis_tready,
    output logic                                      m_axis_tvalid,
    output logic                                      m_axis_tlast,
    output logic [scheduler_pkg::DATA_WIDTH-1:0]      m_axis_tdata,
    output logic [scheduler_pkg::KEEP_WIDTH-1:0]      m_axis_tkeep,
    output logic [scheduler_pkg::META_WIDTH-1:0]      m_axis_tuser,
    output logic [scheduler_pkg::PIFO_INFO_WIDTH-1:0] m_axis_tpifo,
    output logic [$clog2(NUM_SLOTS + 1)-1:0]          q_size
);
    import scheduler_pkg::*;

    localparam int SLOT_WIDTH = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
    localparam int INDEX_WIDTH = (SLOT_WORDS > 1) ? $clog2(SLOT_WORDS) : 1;
    localparam int COUNT_WIDTH = $clog2(PIFO_DEPTH + 1);
    localparam int SIZE_WIDTH = $clog2(NUM_SLOTS + 1);
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_FETCH = 2'd1;
    localparam logic [1:0] ST_SEND = 2'd2;

    logic                       wr_beat;
    logic                       in_pkt;
    logic [RANK_WIDTH-1:0]      rank;
    logic [SLOT_WIDTH-1:0]      wr_slot;
    logic [SLOT_WIDTH-1:0]      rd_slot_q;
    logic [INDEX_WIDTH-1:0]     rd_index;
    logic [INDEX_WIDTH-1:0]     rd_index_q;
    logic [WORD_WIDTH-1:0]      rd_word;
    logic                       buf_full;
    logic                       cal_full;
    logic                       head_valid;
    logic [SLOT_WIDTH-1:0]      head_slot;
    logic [PIFO_INFO_WIDTH-1:0] head_info;
    logic [PIFO_INFO_WIDTH-1:0] cur_info;
    logic [COUNT_WIDTH-1:0]     pifo_count;
    logic [1:0]                 state;
    logic                       pop_en;
    logic                       xfer;
    logic                       free_en;

    ////////////////////////////////////////////////////////////////////////////
    // Enqueue side
    assign wr_beat = ctl.wr_en[QUEUE_INDEX] && in_bus.valid;
    assign ctl.buffer_full[QUEUE_INDEX] = buf_full;
    assign ctl.pifo_full[QUEUE_INDEX] = cal_full;

    // Unranked packets go behind everything else
    assign rank = in_bus.pifo_info[PIFO_VALID_BIT] ? in_bus.pifo_info[RANK_WIDTH-1:0] : '1;

    always_ff @(posedge axis_aclk) begin
        if (reset) begin
            in_pkt <= 1'b0;
        end else if (wr_beat) begin
            in_pkt <= !in_bus.last;
        end
    end

    packet_buffer #(.NUM_SLOTS(NUM_SLOTS), .SLOT_WORDS(SLOT_WORDS)) u_buffer (
        .axis_aclk (axis_aclk),
        .reset     (reset),
        .wr_en     (wr_beat),
        .wr_first  (!in_pkt),
        .wr_last   (in_bus.last),
        .wr_word   ({in_bus.meta, in_bus.last, in_bus.keep, in_bus.data}),
        .wr_slot   (wr_slot),
        .rd_slot   (rd_slot_q),
        .rd_index  (rd_index),
        .rd_word   (rd_word),
        .free_en   (free_en),
        .free_slot (rd_slot_q),
        .full      (buf_full)
    );

    pifo_calendar #(.PIFO_DEPTH(PIFO_DEPTH), .SLOT_WIDTH(SLOT_WIDTH)) u_calendar (
        .axis_aclk   (axis_aclk),
        .reset       (reset),
        .insert_en   (ctl.pifo_insert_en[QUEUE_INDEX]),
        .insert_rank (rank),
        .insert_slot (wr_slot),
        .insert_info (in_bus.pifo_info),
        .pop_en      (pop_en),
        .head_valid  (head_valid),
        .head_slot   (head_slot),
        .head_info   (head_info),
        .count       (pifo_count),
        .full        (cal_full)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Dequeue FSM with the buffer read register as the egress stage
    assign pop_en = (state == ST_IDLE) && head_valid;
    assign xfer = m_axis_tvalid && m_axis_tready;
    assign free_en = xfer && m_axis_tlast;
    // Stalled beat re-reads the same word so the output holds
    assign rd_index = (xfer && !m_axis_tlast) ? rd_index_q + 1'b1 : rd_index_q;

    always_ff @(posedge axis_aclk) begin
        if (reset) begin
            state <= ST_IDLE;
            m_axis_tvalid <= 1'b0;
            rd_index_q <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pop_en) begin
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    state <= ST_SEND;
                    m_axis_tvalid <= 1'b1;
                end
                ST_SEND: begin
                    if (free_en) begin
                        state <= ST_IDLE;
                        m_axis_tvalid <= 1'b0;
                        rd_index_q <= '0;
                    end else begin
                        rd_index_q <= rd_index;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge axis_aclk) begin
        if (pop_en) begin
            rd_slot_q <= head_slot;
            cur_info <= head_info;
        end
    end

    assign m_axis_tdata = rd_word[DATA_WIDTH-1:0];
    assign m_axis_tkeep = rd_word[LAST_BIT-1:KEEP_LSB];
    assign m_axis_tlast = rd_word[LAST_BIT];
    assign m_axis_tuser = rd_word[WORD_WIDTH-1:META_LSB];
    assign m_axis_tpifo = cur_info;

    // Filed packets plus the one in flight
    assign q_size = SIZE_WIDTH'(pifo_count) + SIZE_WIDTH'(state != ST_IDLE);

    // Egress beat held steady under back-pressure
    assert property (@(posedge axis_aclk) disable iff (reset)
        m_axis_tvalid && !m_axis_tready |=>
            m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast));

endmodule

// File: rtl/enqueue_agent.sv
`timescale 1ns/10ps

module enqueue_agent (
    input  logic                                 axis_aclk,
    input  logic                                 reset,
    input  logic                                 s_axis_tvalid,
    input  logic                                 s_axis_tlast,
    input  logic [scheduler_pkg::NUM_QUEUES-1:0] dst_bitmap,
    output logic                                 s_axis_tready,
    queue_ctl_if.agent                           ctl,
    output logic [scheduler_pkg::NUM_QUEUES-1:0] pkt_dropped
);
    import scheduler_pkg::*;

    logic                  beat;
    logic                  first_beat;
    logic [NUM_QUEUES-1:0] blocked;
    logic [NUM_QUEUES-1:0] admit_now;
    logic [NUM_QUEUES-1:0] admit_held;
    logic [NUM_QUEUES-1:0] admit_set;

    assign beat = s_axis_tvalid && s_axis_tready;

    // Admission decided at the first beat only and held to last
    assign blocked = ctl.buffer_full | ctl.pifo_full;
    assign admit_now = dst_bitmap & ~blocked;
    assign admit_set = first_beat ? admit_now : admit_held;

    assign ctl.wr_en = beat ? admit_set : '0;
    assign ctl.pifo_insert_en = (beat && s_axis_tlast) ? admit_set : '0;
    assign pkt_dropped = (beat && first_beat) ? (dst_bitmap & blocked) : '0;

    always_ff @(posedge axis_aclk) begin
        if (reset) begin
            s_axis_tready <= 1'b0;
            first_beat <= 1'b1;
            admit_held <= '0;
        end else begin
            s_axis_tready <= 1'b1;
            if (beat) begin
                first_beat <= s_axis_tlast;
                if (first_beat) begin
                    admit_held <= admit_now;
                end
            end
        end
    end

endmodule

// File: rtl/scheduler_top.sv
`timescale 1ns/10ps

module scheduler_top #(
    parameter int NUM_SLOTS  = scheduler_pkg::DEFAULT_NUM_SLOTS,
    parameter int SLOT_WORDS = scheduler_pkg::DEFAULT_SLOT_WORDS,
    parameter int PIFO_DEPTH = scheduler_pkg::DEFAULT_PIFO_DEPTH
) (
    input  logic                                          axis_aclk,
    input  logic                                          reset,

    input  logic [scheduler_pkg::DATA_WIDTH-1:0]          s_axis_tdata,
    input  logic [scheduler_pkg::KEEP_WIDTH-1:0]          s_axis_tkeep,
    input  logic [scheduler_pkg::TUSER_WIDTH-1:0]         s_axis_tuser,
    input  logic                                          s_axis_tvalid,
    input  logic                                          s_axis_tlast,
    output logic                                          s_axis_tready,

    input  logic [scheduler_pkg::NUM_QUEUES-1:0]          m_axis_tready,
    output logic [scheduler_pkg::NUM_QUEUES-1:0]          m_axis_tvalid,
    output logic [scheduler_pkg::NUM_QUEUES-1:0]          m_axis_tlast,
    output logic [scheduler_pkg::NUM_QUEUES-1:0][scheduler_pkg::DATA_WIDTH-1:0] m_axis_tdata,
    output logic [scheduler_pkg::NUM_QUEUES-1:0][scheduler_pkg::KEEP_WIDTH-1:0] m_axis_tkeep,
    output logic [scheduler_pkg::NUM_QUEUES-1:0][scheduler_pkg::META_WIDTH-1:0] m_axis_tuser,
    output logic [scheduler_pkg::NUM_QUEUES-1:0][scheduler_pkg::PIFO_INFO_WIDTH-1:0] m_axis_tpifo,

    output logic [scheduler_pkg::NUM_QUEUES-1:0][$clog2(NUM_SLOTS + 1)-1:0] q_size,
    output logic [scheduler_pkg::NUM_QUEUES-1:0]          pkt_dropped
);
    import scheduler_pkg::*;

    ingress_if   in_bus ();
    queue_ctl_if ctl ();

    ////////////////////////////////////////////////////////////////////////////
    // Ingress word goes to every queue, user word split in two
    assign in_bus.valid = s_axis_tvalid;
    assign in_bus.last = s_axis_tlast;
    assign in_bus.data = s_axis_tdata;
    assign in_bus.keep = s_axis_tkeep;
    assign in_bus.meta = s_axis_tuser[META_WIDTH-1:0];
    assign in_bus.pifo_info = s_axis_tuser[TUSER_WIDTH-1:META_WIDTH];

    enqueue_agent u_agent (
        .axis_aclk     (axis_aclk),
        .reset         (reset),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tlast  (s_axis_tlast),
        .dst_bitmap    (s_axis_tuser[NUM_QUEUES-1:0]),
        .s_axis_tready (s_axis_tready),
        .ctl           (ctl.agent),
        .pkt_dropped   (pkt_dropped)
    );

    ////////////////////////////////////////////////////////////////////////////
    // One output queue per egress port
    for (genvar g = 0; g < NUM_QUEUES; g++) begin : g_queue
        output_queue #(
            .QUEUE_INDEX (g),
            .NUM_SLOTS   (NUM_SLOTS),
            .SLOT_WORDS  (SLOT_WORDS),
            .PIFO_DEPTH  (PIFO_DEPTH)
        ) u_queue (
            .axis_aclk     (axis_aclk),
            .reset         (reset),
            .in_bus        (in_bus.sink),
            .ctl           (ctl.queue),
            .m_axis_tready (m_axis_tready[g]),
            .m_axis_tvalid (m_axis_tvalid[g]),
            .m_axis_tlast  (m_axis_tlast[g]),
            .m_axis_tdata  (m_axis_tdata[g]),
            .m_axis_tkeep  (m_axis_tkeep[g]),
            .m_axis_tuser  (m_axis_tuser[g]),
            .m_axis_tpifo  (m_axis_tpifo[g]),
            .q_size        (q_size[g])
        );
    end

endmodule

// File: tests/scheduler_tb.sv
`timescale 1ns/10ps

module scheduler_tb;
    import scheduler_pkg::*;

    localparam int NUM_SLOTS = 8;
    localparam int SLOT_WORDS = 8;
    localparam int PIFO_DEPTH = 8;
    localparam int MAX_PKTS = 64;
    localparam int WAIT_LIMIT = 3000;

    logic                                             axis_aclk = 1'b0;
    logic                                             reset;
    logic [DATA_WIDTH-1:0]                            s_axis_tdata;
    logic [KEEP_WIDTH-1:0]                            s_axis_tkeep;
    logic [TUSER_WIDTH-1:0]                           s_axis_tuser;
    logic                                             s_axis_tvalid;
    logic                                             s_axis_tlast;
    logic                                             s_axis_tready;
    logic [NUM_QUEUES-1:0]                            m_axis_tready;
    logic [NUM_QUEUES-1:0]                            m_axis_tvalid;
    logic [NUM_QUEUES-1:0]                            m_axis_tlast;
    logic [NUM_QUEUES-1:0][DATA_WIDTH-1:0]            m_axis_tdata;
    logic [NUM_QUEUES-1:0][KEEP_WIDTH-1:0]            m_axis_tkeep;
    logic [NUM_QUEUES-1:0][META_WIDTH-1:0]            m_axis_tuser;
    logic [NUM_QUEUES-1:0][PIFO_INFO_WIDTH-1:0]       m_axis_tpifo;
    logic [NUM_QUEUES-1:0][$clog2(NUM_SLOTS + 1)-1:0] q_size;
    logic [NUM_QUEUES-1:0]                            pkt_dropped;

    // Packet store by id
    int                         pkt_len [MAX_PKTS];
    logic [DATA_WIDTH-1:0]      pkt_data [MAX_PKTS][SLOT_WORDS];
    logic [KEEP_WIDTH-1:0]      pkt_keep [MAX_PKTS][SLOT_WORDS];
    logic [META_WIDTH-1:0]      pkt_meta [MAX_PKTS];
    logic [PIFO_INFO_WIDTH-1:0] pkt_info [MAX_PKTS];
    logic [RANK_WIDTH-1:0]      pkt_rank [MAX_PKTS];
    int                         pkt_stamp [MAX_PKTS];

    // Scoreboard lists kept in rank order with arrival order among equals
    int    exp_id [NUM_QUEUES][MAX_PKTS];
    int    exp_cnt [NUM_QUEUES];
    int    occ [NUM_QUEUES];
    logic  active [NUM_QUEUES];
    int    cur_id [NUM_QUEUES];
    int    beat_idx [NUM_QUEUES];
    int    cyc = 0;
    int    next_id = 0;
    int    errors = 0;
    int    checks = 0;
    int    tests = 0;
    int    err_start = 0;
    logic  rand_ready = 1'b0;
    string test_name = "reset";

    scheduler_top #(
        .NUM_SLOTS  (NUM_SLOTS),
        .SLOT_WORDS (SLOT_WORDS),
        .PIFO_DEPTH (PIFO_DEPTH)
    ) DUT (.*);

    always #20 axis_aclk = ~axis_aclk;

    always @(posedge axis_aclk) begin
        cyc <= cyc + 1;
    end

    always @(posedge axis_aclk) begin
        if (rand_ready) begin
            #2 m_axis_tready = NUM_QUEUES'($urandom);
        end
    end

    task automatic check_equal(string what, logic [159:0] expected, logic [159:0] actual);
        checks++;
        assert (actual == expected) else begin
            $display("ERR %s: %s expected %0h, got %0h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_true(string what, logic cond);
        checks++;
        assert (cond) else begin
            $display("%s: %s", test_name, what);
            errors++;
        end
    endtask

    task automatic file_expected(int q, int id);
        int pos;
        pos = exp_cnt[q];
        for (int i = exp_cnt[q] - 1; i >= 0; i--) begin
            if (pkt_rank[exp_id[q][i]] > pkt_rank[id]) begin
                pos = i;
            end
        end
        for (int i = exp_cnt[q]; i > pos; i--) begin
            exp_id[q][i] = exp_id[q][i-1];
        end
        exp_id[q][pos] = id;
        exp_cnt[q]++;
    endtask

    task automatic remove_expected(int q, int pos);
        for (int i = pos; i < exp_cnt[q] - 1; i++) begin
            exp_id[q][i] = exp_id[q][i+1];
        end
        exp_cnt[q]--;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Ingress driver
    task automatic send_packet(logic [NUM_QUEUES-1:0] dst, logic ranked,
                               logic [RANK_WIDTH-1:0] rank, int len);
        int                    id;
        int                    n;
        logic                  ok;
        logic [NUM_QUEUES-1:0] full_now;
        logic [NUM_QUEUES-1:0] dropped;
        id = next_id;
        next_id++;
        pkt_len[id] = len;
        pkt_meta[id] = {id[23:0], 3'b000, dst};
        pkt_info[id] = {ranked, 15'd0, rank};
        pkt_rank[id] = ranked ? rank : '1;
        pkt_stamp[id] = 32'h7fff_ffff;
        for (int w = 0; w < len; w++) begin
            pkt_data[id][w] = {$urandom, $urandom};
            pkt_keep[id][w] = (w == len - 1) ? (KEEP_WIDTH'($urandom) | KEEP_WIDTH'(1)) : '1;
        end
        // A queue holding NUM_SLOTS packets has no free slot
        full_now = '0;
        dropped = '0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            full_now[q] = (occ[q] >= NUM_SLOTS);
            if (dst[q] && !full_now[q]) begin
                file_expected(q, id);
                occ[q]++;
            end
        end
        for (int w = 0; w < len; w++) begin
            s_axis_tvalid = 1'b1;
            s_axis_tdata = pkt_data[id][w];
            s_axis_tkeep = pkt_keep[id][w];
            s_axis_tlast = (w == len - 1);
            s_axis_tuser = {pkt_info[id], pkt_meta[id]};
            ok = 1'b0;
            for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
                @(negedge axis_aclk);
                ok = s_axis_tready;
                dropped = pkt_dropped;
                if (ok && w == len - 1) begin
                    pkt_stamp[id] = cyc;
                end
                @(posedge axis_aclk);
                #2;
            end
            check_true("ingress timed out waiting for tready", ok);
            if (w == 0) begin
                check_equal("pkt_dropped", dst & full_now, dropped);
            end
        end
        s_axis_tvalid = 1'b0;
        s_axis_tlast = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Egress monitors
    task automatic start_packet(int q);
        int id;
        int pick;
        int pos;
        id = int'(m_axis_tuser[q][META_WIDTH-1:8]);
        pick = -1;
        pos = -1;
        // Calendar holds only packets filed at least three cycles back
        for (int i = exp_cnt[q] - 1; i >= 0; i--) begin
            if (pkt_stamp[exp_id[q][i]] <= cyc - 3) begin
                pick = i;
            end
            if (exp_id[q][i] == id) begin
                pos = i;
            end
        end
        cur_id[q] = -1;
        if (pos < 0) begin
            check_true($sformatf("unexpected packet %0d on queue %0d", id, q), 1'b0);
        end else begin
            check_equal($sformatf("queue %0d packet order", q),
                        (pick < 0) ? -1 : exp_id[q][pick], id);
            cur_id[q] = id;
            remove_expected(q, pos);
        end
    endtask

    task automatic check_beat(int q);
        int   id;
        int   w;
        logic exp_last;
        id = cur_id[q];
        w = beat_idx[q];
        if (id >= 0 && w < SLOT_WORDS) begin
            exp_last = (w == pkt_len[id] - 1);
            check_equal($sformatf("queue %0d beat %0d", q, w),
                {pkt_info[id], pkt_meta[id], exp_last, pkt_keep[id][w], pkt_data[id][w]},
                {m_axis_tpifo[q], m_axis_tuser[q], m_axis_tlast[q], m_axis_tkeep[q],
                 m_axis_tdata[q]});
        end
        beat_idx[q]++;
        if (m_axis_tlast[q]) begin
            active[q] = 1'b0;
            occ[q]--;
        end
    endtask

    always @(negedge axis_aclk) begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (m_axis_tvalid[q] && !active[q]) begin
                active[q] = 1'b1;
                beat_idx[q] = 0;
                start_packet(q);
            end
            if (m_axis_tvalid[q] && m_axis_tready[q] && active[q]) begin
                check_beat(q);
            end
        end
    end

    function automatic logic all_empty();
        logic empty;
        empty = 1'b1;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (exp_cnt[q] != 0 || active[q]) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    task automatic wait_drained();
        int n;
        n = 0;
        while (n < WAIT_LIMIT && !all_empty()) begin
            @(posedge axis_aclk);
            #2;
            n++;
        end
        check_true("queues did not drain before the timeout", all_empty());
        @(negedge axis_aclk);
        for (int q = 0; q < NUM_QUEUES; q++) begin
            check_equal($sformatf("q_size[%0d]", q), 0, q_size[q]);
        end
        @(posedge axis_aclk);
        #2;
    endtask

    task automatic begin_test(string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s: %0d errors", test_name, errors - err_start);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    task automatic test_unicast_order();
        logic [RANK_WIDTH-1:0] ranks [4];
        ranks = '{16'd5, 16'd2, 16'd9, 16'd2};
        begin_test("unicast_order");
        m_axis_tready = '0;
        for (int i = 0; i < 4; i++) begin
            send_packet(5'b00001, 1'b1, ranks[i], 1 + $urandom % SLOT_WORDS);
        end
        m_axis_tready = '1;
        wait_drained();
        end_test();
    endtask

    task automatic test_multicast();
        begin_test("multicast");
        m_axis_tready = '1;
        send_packet(5'b11010, 1'b1, RANK_WIDTH'($urandom), 4);
        wait_drained();
        end_test();
    endtask

    task automatic test_invalid_rank();
        begin_test("invalid_rank");
        m_axis_tready = '0;
        send_packet(5'b01000, 1'b1, RANK_WIDTH'($urandom % 16'h7fff), 2);
        send_packet(5'b01000, 1'b0, 16'd0, 3);
        for (int i = 0; i < 3; i++) begin
            send_packet(5'b01000, 1'b1, RANK_WIDTH'($urandom % 16'h7fff), 2);
        end
        m_axis_tready = '1;
        wait_drained();
        end_test();
    endtask

    task automatic test_overflow();
        begin_test("overflow");
        m_axis_tready = '0;
        // Last packet finds every slot taken
        for (int i = 0; i < NUM_SLOTS + 1; i++) begin
            send_packet(5'b00100, 1'b1, RANK_WIDTH'($urandom), 1 + $urandom % 3);
        end
        @(negedge axis_aclk);
        check_equal("q_size[2]", NUM_SLOTS, q_size[2]);
        @(posedge axis_aclk);
        #2;
        m_axis_tready = '1;
        wait_drained();
        end_test();
    endtask

    task automatic test_back_pressure();
        logic [NUM_QUEUES-1:0] dst;
        begin_test("back_pressure");
        rand_ready = 1'b1;
        for (int i = 0; i < 30; i++) begin
            dst = NUM_QUEUES'($urandom);
            if (dst == '0) begin
                dst = 5'b00001;
            end
            send_packet(dst, ($urandom % 4) != 0, RANK_WIDTH'($urandom),
                        1 + $urandom % SLOT_WORDS);
        end
        wait_drained();
        rand_ready = 1'b0;
        @(posedge axis_aclk);
        #2;
        m_axis_tready = '1;
        end_test();
    endtask

    initial begin
        void'($urandom(32'hec5d_1ae7));
        reset = 1'b1;
        s_axis_tdata = '0;
        s_axis_tkeep = '0;
        s_axis_tuser = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast = 1'b0;
        m_axis_tready = '0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            exp_cnt[q] = 0;
            occ[q] = 0;
            active[q] = 1'b0;
            cur_id[q] = -1;
            beat_idx[q] = 0;
        end
        repeat (5) @(posedge axis_aclk);
        #2;
        reset = 1'b0;

        test_unicast_order();
        test_multicast();
        test_invalid_rank();
        test_overflow();
        test_back_pressure();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: vlog.f
rtl/scheduler_pkg.sv
rtl/ingress_if.sv
rtl/queue_ctl_if.sv
rtl/packet_buffer.sv
rtl/pifo_calendar.sv
rtl/output_queue.sv
rtl/enqueue_agent.sv
rtl/scheduler_top.sv
tests/scheduler_tb.sv

// File: Bender.yml
package:
  name: pifo_scheduler

sources:
  - files:
      - rtl/scheduler_pkg.sv
      - rtl/ingress_if.sv
      - rtl/queue_ctl_if.sv
      - rtl/packet_buffer.sv
      - rtl/pifo_calendar.sv
      - rtl/output_queue.sv
      - rtl/enqueue_agent.sv
      - rtl/scheduler_top.sv
  - target: test
    files:
      - tests/scheduler_tb.sv
